// File: Makefile
# Verilator build for the MEM/WB slice

VERILATOR  ?= verilator
TOP        ?= tb_mem_wb
RTL_TOP    ?= mem_wb_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
JOBS       ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run exits non-zero on any $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+common
common/cpu_pkg.sv
data_ram/data_ram.sv
mem_stage/mem_stage.sv
verilog/wb_stage.sv
verilog/mem_wb_top.sv
tests/tb_mem_wb.sv

// File: common/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// load handling

	// how write-back forms the register value
	typedef enum logic [2:0] {
		LK_NONE = 3'd0,
		LK_LB   = 3'd1,
		LK_LBU  = 3'd2,
		LK_LH   = 3'd3,
		LK_LHU  = 3'd4,
		LK_LW   = 3'd5
	} load_kind_t;

	// anything other than none reads the RAM word
	function automatic logic is_load(load_kind_t kind);
		return kind != LK_NONE;
	endfunction

	////////////////////////////////////////////////////////////
	// read data word

	// byte lane 0 and halfword lane 0 are the low-order bits
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} rdata_word_u;

endpackage

// File: common/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// data RAM depth, in 32-bit words
`define DATA_RAM_WORDS 256

// word index width into the data RAM
`define DATA_RAM_AW ($clog2(`DATA_RAM_WORDS))

// register file address width
`define RF_ADDR_W 5

`endif

// File: data_ram/data_ram.sv
`include "pipe_settings.svh"

module data_ram (
	input  logic                    clk,
	input  logic                    en,
	input  logic                    we,
	input  logic [3:0]              byte_en,
	input  logic [`DATA_RAM_AW-1:0] addr,
	input  logic [31:0]             wdata,
	output logic [31:0]             rdata
);

	logic [31:0] mem [`DATA_RAM_WORDS];

	// read returns the old word, lanes written on the same edge
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			rdata <= mem[addr];
			for (int i = 0; i < 4; i++)
			begin
				if (we && byte_en[i])
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// the word index from execute must land inside the array
	a_addr_in_range: assert property (
		@(posedge clk) en |-> (int'(addr) < `DATA_RAM_WORDS)
	) else $error("data RAM address %0d out of range", addr);

endmodule

// File: mem_stage/mem_stage.sv
`include "pipe_settings.svh"

module mem_stage (
	input  logic                     clk,
	input  logic                     reset,

	// from execute
	input  logic                     in_valid,
	input  logic [31:0]              in_pc,
	input  logic [31:0]              in_alu_result,
	input  logic                     in_rf_we,
	input  logic [`RF_ADDR_W-1:0]    in_rf_waddr,
	input  cpu_pkg::load_kind_t      in_load_kind,
	input  logic [31:0]              ram_rdata,
	output logic                     allow_in,

	// to write-back
	input  logic                     wb_allow_in,
	output logic                     out_valid,
	output logic [31:0]              out_pc,
	output logic [31:0]              out_alu_result,
	output logic                     out_rf_we,
	output logic [`RF_ADDR_W-1:0]    out_rf_waddr,
	output cpu_pkg::load_kind_t      out_load_kind,
	output cpu_pkg::rdata_word_u     out_rdata,

	// bypass toward decode
	output logic                     byp_valid,
	output logic [`RF_ADDR_W-1:0]    byp_waddr,
	output logic [31:0]              byp_data,
	output logic                     byp_is_load
);

	import cpu_pkg::*;

	logic        valid;
	logic        first;
	logic [31:0] rdata_hold;

	////////////////////////////////////////////////////////////
	// handshake

	// access finishes in one cycle
	assign allow_in  = !valid || wb_allow_in;
	assign out_valid = valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= 1'b0;
		else if (allow_in)
			valid <= in_valid;
	end

	// high only in the cycle right after an accept
	always_ff @(posedge clk)
	begin
		if (reset)
			first <= 1'b0;
		else
			first <= in_valid && allow_in;
	end

	////////////////////////////////////////////////////////////
	// EXE/MEM register

	always_ff @(posedge clk)
	begin
		if (in_valid && allow_in)
		begin
			out_pc         <= in_pc;
			out_alu_result <= in_alu_result;
			out_rf_we      <= in_rf_we;
			out_rf_waddr   <= in_rf_waddr;
			out_load_kind  <= in_load_kind;
		end
	end

	////////////////////////////////////////////////////////////
	// read data capture

	always_ff @(posedge clk)
	begin
		if (first)
			rdata_hold <= ram_rdata;
	end

	// live RAM output on the first cycle, held copy after that
	assign out_rdata = first ? ram_rdata : rdata_hold;

	////////////////////////////////////////////////////////////
	// bypass

	assign byp_valid   = valid && out_rf_we;
	assign byp_waddr   = out_rf_waddr;
	assign byp_data    = out_alu_result;
	assign byp_is_load = is_load(out_load_kind);

	// a stalled offer keeps its whole payload, read data included
	a_hold_stable: assert property (
		@(posedge clk) disable iff (reset)
		out_valid && !wb_allow_in |=> out_valid && $stable(out_pc) &&
			$stable(out_alu_result) && $stable(out_rf_we) &&
			$stable(out_rf_waddr) && $stable(out_load_kind) && $stable(out_rdata)
	) else $error("MEM payload changed while stalled");

	a_reset_empty: assert property (
		@(posedge clk) reset |=> !out_valid
	) else $error("MEM valid after reset");

endmodule

// File: tests/tb_mem_wb.sv
`include "pipe_settings.svh"

module tb_mem_wb;

	import cpu_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int INIT_WORDS = 32;
	localparam int N_RANDOM   = 400;
	localparam int N_TOTAL    = INIT_WORDS + N_RANDOM;
	localparam int TIMEOUT    = N_TOTAL * 40 * CLK_PERIOD;

	// one expected register write
	typedef struct packed {
		logic [`RF_ADDR_W-1:0] waddr;
		logic [31:0]           data;
		logic [31:0]           alu;
		logic                  is_load;
	} exp_t;

	logic                  clk;
	logic                  reset;
	logic                  retire_hold;
	logic                  exe_valid;
	logic [31:0]           exe_pc;
	logic [31:0]           exe_alu_result;
	logic                  exe_rf_we;
	logic [`RF_ADDR_W-1:0] exe_rf_waddr;
	load_kind_t            exe_load_kind;
	logic                  exe_store;
	logic [3:0]            exe_byte_en;
	logic [31:0]           exe_store_data;
	logic                  mem_allow_in;
	logic                  rf_we;
	logic [`RF_ADDR_W-1:0] rf_waddr;
	logic [31:0]           rf_wdata;
	logic                  byp_mem_valid;
	logic [`RF_ADDR_W-1:0] byp_mem_waddr;
	logic [31:0]           byp_mem_data;
	logic                  byp_mem_is_load;
	logic                  byp_wb_valid;
	logic [`RF_ADDR_W-1:0] byp_wb_waddr;
	logic [31:0]           byp_wb_data;

	logic [31:0]             rng_state;
	logic [31:0]             shadow [`DATA_RAM_WORDS];
	exp_t                    exp_q [$];
	exp_t                    head0;
	exp_t                    head1;
	exp_t                    mem_next;
	exp_t                    ent;
	logic [`DATA_RAM_AW-1:0] widx;
	int                      q_size;
	int                      issued;
	logic                    seen_accept;
	logic                    took;
	logic [31:0]             r;

	mem_wb_top i_dut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic roll(output logic [31:0] v);
		rng_state = lcg_next(rng_state);
		v = rng_state;
	endtask

	task automatic fail_check(input string what);
		$display("mismatch at time %0t: %s", $time, what);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	// register value a load produces from a whole RAM word
	function automatic logic [31:0] extract_load(input logic [31:0] word,
			input logic [1:0] off, input load_kind_t kind);
		logic [31:0] sh;
		sh = word >> {off, 3'b000};
		case (kind)
			LK_LB:   return {{24{sh[7]}}, sh[7:0]};
			LK_LBU:  return {24'd0, sh[7:0]};
			LK_LH:   return {{16{sh[15]}}, sh[15:0]};
			LK_LHU:  return {16'd0, sh[15:0]};
			default: return word;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus

	// first INIT_WORDS instructions fill the load window with full-word stores
	task automatic offer_instr(input int idx);
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] alu;
		logic [3:0]  be;
		load_kind_t  kind;
		logic        st;
		logic        we;
		int          sel;
		roll(r);
		roll(a);
		roll(d);
		sel  = (idx < INIT_WORDS) ? 0 : int'(r[31:16] % 16'd10);
		kind = LK_NONE;
		st   = 1'b0;
		we   = 1'b1;
		be   = (a[26:23] == 4'd0) ? 4'hf : a[26:23];
		alu  = {25'd0, a[31:27], a[20:19]};
		case (sel)
			0, 1:
			begin
				st = 1'b1;
				we = 1'b0;
			end
			2: kind = LK_LB;
			3: kind = LK_LBU;
			4: kind = LK_LH;
			5: kind = LK_LHU;
			6: kind = LK_LW;
			7, 8: alu = a;
			default:
			begin
				we  = 1'b0;
				alu = a;
			end
		endcase
		if (kind == LK_LH || kind == LK_LHU)
			alu[0] = 1'b0;
		if (kind == LK_LW)
			alu[1:0] = 2'b00;
		if (idx < INIT_WORDS)
		begin
			be  = 4'hf;
			alu = idx << 2;
		end
		exe_valid      <= 1'b1;
		exe_pc         <= 32'h0000_1000 + (idx << 2);
		exe_alu_result <= alu;
		exe_rf_we      <= we;
		exe_rf_waddr   <= d[31 -: `RF_ADDR_W];
		exe_load_kind  <= kind;
		exe_store      <= st;
		exe_byte_en    <= st ? be : 4'd0;
		exe_store_data <= d;
	endtask

	initial
	begin
		rng_state      = 32'h4bf6_e38e;
		reset          = 1'b1;
		retire_hold    = 1'b0;
		exe_valid      = 1'b0;
		exe_pc         = 32'd0;
		exe_alu_result = 32'd0;
		exe_rf_we      = 1'b0;
		exe_rf_waddr   = '0;
		exe_load_kind  = LK_NONE;
		exe_store      = 1'b0;
		exe_byte_en    = 4'd0;
		exe_store_data = 32'd0;
		issued         = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		while (issued < N_TOTAL)
		begin
			@(posedge clk);
			took = exe_valid && mem_allow_in;
			if (took)
				issued++;
			// a pending offer stays until it is taken
			if (took || !exe_valid)
			begin
				roll(r);
				if (issued < N_TOTAL && r[31:28] < 4'd12)
					offer_instr(issued);
				else
					exe_valid <= 1'b0;
			end
			roll(r);
			retire_hold <= (r[31:24] < 8'd70);
		end
		retire_hold <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		// room for a stray extra write to show up
		repeat (4) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT);
		$display("run hung: not all register writes retired in %0d time units", TIMEOUT);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// reference model

	initial
	begin
		seen_accept = 1'b0;
		q_size      = 0;
		head0       = '0;
		head1       = '0;
	end

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (rf_we && exp_q.size() != 0)
				void'(exp_q.pop_front());
			if (exe_valid && mem_allow_in)
			begin
				seen_accept = 1'b1;
				widx = exe_alu_result[`DATA_RAM_AW+1:2];
				if (exe_rf_we)
				begin
					ent.waddr   = exe_rf_waddr;
					ent.alu     = exe_alu_result;
					ent.is_load = (exe_load_kind != LK_NONE);
					if (ent.is_load)
						ent.data = extract_load(shadow[widx], exe_alu_result[1:0],
							exe_load_kind);
					else
						ent.data = exe_alu_result;
					exp_q.push_back(ent);
				end
				// merge only the enabled byte lanes
				if (exe_store)
				begin
					for (int i = 0; i < 4; i++)
					begin
						if (exe_byte_en[i])
							shadow[widx][i*8 +: 8] = exe_store_data[i*8 +: 8];
					end
				end
			end
			q_size = exp_q.size();
			head0  = (q_size > 0) ? exp_q[0] : '0;
			head1  = (q_size > 1) ? exp_q[1] : '0;
		end
	end

	// MEM holds the entry behind the WB one when WB has a pending write
	assign mem_next = byp_wb_valid ? head1 : head0;

	////////////////////////////////////////////////////////////
	// checks

	a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
		!seen_accept |-> !rf_we && !byp_mem_valid && !byp_wb_valid && mem_allow_in)
		else fail_check("pipeline not idle before the first accept");

	a_write_expected: assert property (@(posedge clk) disable iff (reset)
		rf_we |-> q_size != 0)
		else fail_check("register write with no instruction pending");

	a_write_port: assert property (@(posedge clk) disable iff (reset)
		rf_we |-> rf_waddr == head0.waddr && rf_wdata == head0.data)
		else fail_check($sformatf("write x%0d = %h, expected x%0d = %h",
			rf_waddr, rf_wdata, head0.waddr, head0.data));

	a_hold_blocks_write: assert property (@(posedge clk) disable iff (reset)
		retire_hold |-> !rf_we)
		else fail_check("register write while retire_hold is high");

	a_full_stalls: assert property (@(posedge clk) disable iff (reset)
		retire_hold && byp_mem_valid && byp_wb_valid |-> !mem_allow_in)
		else fail_check("mem_allow_in high with both stages full and held");

	a_wb_bypass: assert property (@(posedge clk) disable iff (reset)
		byp_wb_valid |-> q_size != 0 && byp_wb_waddr == head0.waddr &&
			byp_wb_data == head0.data)
		else fail_check("WB bypass differs from the retiring instruction");

	a_wb_bypass_port: assert property (@(posedge clk) disable iff (reset)
		rf_we |-> byp_wb_data == rf_wdata && byp_wb_waddr == rf_waddr)
		else fail_check("WB bypass differs from the write port");

	a_mem_bypass: assert property (@(posedge clk) disable iff (reset)
		byp_mem_valid |-> q_size > (byp_wb_valid ? 1 : 0) &&
			byp_mem_waddr == mem_next.waddr && byp_mem_data == mem_next.alu &&
			byp_mem_is_load == mem_next.is_load)
		else fail_check($sformatf("MEM bypass x%0d = %h, expected x%0d = %h",
			byp_mem_waddr, byp_mem_data, mem_next.waddr, mem_next.alu));

endmodule

// File: verilog/mem_wb_top.sv
`include "pipe_settings.svh"

module mem_wb_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     retire_hold,

	// execute side
	input  logic                     exe_valid,
	input  logic [31:0]              exe_pc,
	input  logic [31:0]              exe_alu_result,
	input  logic                     exe_rf_we,
	input  logic [`RF_ADDR_W-1:0]    exe_rf_waddr,
	input  cpu_pkg::load_kind_t      exe_load_kind,
	input  logic                     exe_store,
	input  logic [3:0]               exe_byte_en,
	input  logic [31:0]              exe_store_data,
	output logic                     mem_allow_in,

	// register file write port
	output logic                     rf_we,
	output logic [`RF_ADDR_W-1:0]    rf_waddr,
	output logic [31:0]              rf_wdata,

	// bypass groups
	output logic                     byp_mem_valid,
	output logic [`RF_ADDR_W-1:0]    byp_mem_waddr,
	output logic [31:0]              byp_mem_data,
	output logic                     byp_mem_is_load,
	output logic                     byp_wb_valid,
	output logic [`RF_ADDR_W-1:0]    byp_wb_waddr,
	output logic [31:0]              byp_wb_data
);

	import cpu_pkg::*;

	logic                  ram_en;
	logic [31:0]           ram_rdata;
	logic                  wb_allow_in;
	logic                  mem_to_wb_valid;
	logic [31:0]           mem_pc;
	logic [31:0]           mem_alu_result;
	logic                  mem_rf_we;
	logic [`RF_ADDR_W-1:0] mem_rf_waddr;
	load_kind_t            mem_load_kind;
	rdata_word_u           mem_rdata;

	// RAM runs only on an accept edge
	assign ram_en = exe_valid && mem_allow_in;

	data_ram i_data_ram (
		.clk     (clk),
		.en      (ram_en),
		.we      (exe_store),
		.byte_en (exe_byte_en),
		.addr    (exe_alu_result[`DATA_RAM_AW+1:2]),
		.wdata   (exe_store_data),
		.rdata   (ram_rdata)
	);

	mem_stage i_mem_stage (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (exe_valid),
		.in_pc          (exe_pc),
		.in_alu_result  (exe_alu_result),
		.in_rf_we       (exe_rf_we),
		.in_rf_waddr    (exe_rf_waddr),
		.in_load_kind   (exe_load_kind),
		.ram_rdata      (ram_rdata),
		.allow_in       (mem_allow_in),
		.wb_allow_in    (wb_allow_in),
		.out_valid      (mem_to_wb_valid),
		.out_pc         (mem_pc),
		.out_alu_result (mem_alu_result),
		.out_rf_we      (mem_rf_we),
		.out_rf_waddr   (mem_rf_waddr),
		.out_load_kind  (mem_load_kind),
		.out_rdata      (mem_rdata),
		.byp_valid      (byp_mem_valid),
		.byp_waddr      (byp_mem_waddr),
		.byp_data       (byp_mem_data),
		.byp_is_load    (byp_mem_is_load)
	);

	wb_stage i_wb_stage (
		.clk           (clk),
		.reset         (reset),
		.retire_hold   (retire_hold),
		.in_valid      (mem_to_wb_valid),
		.in_pc         (mem_pc),
		.in_alu_result (mem_alu_result),
		.in_rf_we      (mem_rf_we),
		.in_rf_waddr   (mem_rf_waddr),
		.in_load_kind  (mem_load_kind),
		.in_rdata      (mem_rdata),
		.allow_in      (wb_allow_in),
		.rf_we         (rf_we),
		.rf_waddr      (rf_waddr),
		.rf_wdata      (rf_wdata),
		.byp_valid     (byp_wb_valid),
		.byp_waddr     (byp_wb_waddr),
		.byp_data      (byp_wb_data)
	);

endmodule

// File: verilog/wb_stage.sv
`include "pipe_settings.svh"

module wb_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     retire_hold,

	// from MEM
	input  logic                     in_valid,
	input  logic [31:0]              in_pc,
	input  logic [31:0]              in_alu_result,
	input  logic                     in_rf_we,
	input  logic [`RF_ADDR_W-1:0]    in_rf_waddr,
	input  cpu_pkg::load_kind_t      in_load_kind,
	input  cpu_pkg::rdata_word_u     in_rdata,
	output logic                     allow_in,

	// register file write port
	output logic                     rf_we,
	output logic [`RF_ADDR_W-1:0]    rf_waddr,
	output logic [31:0]              rf_wdata,

	// bypass toward decode
	output logic                     byp_valid,
	output logic [`RF_ADDR_W-1:0]    byp_waddr,
	output logic [31:0]              byp_data
);

	import cpu_pkg::*;

	logic        valid;
	logic [31:0] pc_q;
	logic [31:0] alu_q;
	logic        rf_we_q;
	load_kind_t  kind_q;
	rdata_word_u rdata_q;
	logic [7:0]  lane_b;
	logic [15:0] lane_h;
	logic [31:0] wdata;

	////////////////////////////////////////////////////////////
	// MEM/WB register

	assign allow_in = !valid || !retire_hold;

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= 1'b0;
		else if (allow_in)
			valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && allow_in)
		begin
			pc_q     <= in_pc;
			alu_q    <= in_alu_result;
			rf_we_q  <= in_rf_we;
			rf_waddr <= in_rf_waddr;
			kind_q   <= in_load_kind;
			rdata_q  <= in_rdata;
		end
	end

	////////////////////////////////////////////////////////////
	// load data extraction

	// lane picked by the low address bits
	assign lane_b = rdata_q.bytes[alu_q[1:0]];
	assign lane_h = rdata_q.halves[alu_q[1]];

	always_comb
	begin
		case (kind_q)
			LK_LB:   wdata = {{24{lane_b[7]}}, lane_b};
			LK_LBU:  wdata = {24'd0, lane_b};
			LK_LH:   wdata = {{16{lane_h[15]}}, lane_h};
			LK_LHU:  wdata = {16'd0, lane_h};
			LK_LW:   wdata = rdata_q;
			default: wdata = alu_q;
		endcase
	end

	// write port, gated by the retire hold
	assign rf_we    = valid && rf_we_q && !retire_hold;
	assign rf_wdata = wdata;

	// bypass sees the value before hold gating
	assign byp_valid = valid && rf_we_q;
	assign byp_waddr = rf_waddr;
	assign byp_data  = wdata;

	a_half_aligned: assert property (
		@(posedge clk) disable iff (reset)
		valid && (kind_q == LK_LH || kind_q == LK_LHU) |-> !alu_q[0]
	) else $error("odd halfword load address at pc %h", pc_q);

endmodule
